// ==== bench/ex_model.svh ====
// reference model with its own HI/LO copy

logic [63:0] model_hilo = '0;

function automatic logic is_acc_op(input ex_isa_pkg::aluop_e op);
    return op inside {ex_isa_pkg::OP_MADD, ex_isa_pkg::OP_MADDU,
                      ex_isa_pkg::OP_MSUB, ex_isa_pkg::OP_MSUBU};
endfunction

function automatic logic [31:0] lead_count(input logic [31:0] v, input logic lead);
    int n;
    n = 0;
    while (n < 32 && v[31 - n] == lead) begin
        n++;
    end
    return n;
endfunction

task automatic predict_result(input ex_pipe_pkg::ex_req_t r, output ex_pipe_pkg::ex_wb_t wb);
    logic [31:0]        a;
    logic [31:0]        b;
    logic [32:0]        wide;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        prod;
    a = r.reg1;
    b = r.reg2;
    sa = $signed(a);
    sb = $signed(b);
    if (r.aluop inside {ex_isa_pkg::OP_MUL, ex_isa_pkg::OP_MULT,
                        ex_isa_pkg::OP_MADD, ex_isa_pkg::OP_MSUB}) begin
        prod = sa * sb;
    end else begin
        prod = {32'h0, a} * {32'h0, b};
    end
    wb = '{wd: r.wd, wreg: r.wreg, ov: 1'b0, wdata: '0};
    case (r.aluop)
        ex_isa_pkg::OP_AND:  wb.wdata = a & b;
        ex_isa_pkg::OP_OR:   wb.wdata = a | b;
        ex_isa_pkg::OP_XOR:  wb.wdata = a ^ b;
        ex_isa_pkg::OP_NOR:  wb.wdata = ~(a | b);
        ex_isa_pkg::OP_SLL:  wb.wdata = b << a[4:0];
        ex_isa_pkg::OP_SRL:  wb.wdata = b >> a[4:0];
        ex_isa_pkg::OP_SRA:  wb.wdata = $signed(b) >>> a[4:0];
        ex_isa_pkg::OP_ADDU: wb.wdata = a + b;
        ex_isa_pkg::OP_SUBU: wb.wdata = a - b;
        ex_isa_pkg::OP_ADD, ex_isa_pkg::OP_SUB: begin
            // 33-bit signed result, overflow when the top two bits differ
            if (r.aluop == ex_isa_pkg::OP_ADD) begin
                wide = {a[31], a} + {b[31], b};
            end else begin
                wide = {a[31], a} - {b[31], b};
            end
            wb.wdata = wide[31:0];
            wb.ov    = wide[32] != wide[31];
        end
        ex_isa_pkg::OP_SLT:  wb.wdata = {31'h0, $signed(a) < $signed(b)};
        ex_isa_pkg::OP_SLTU: wb.wdata = {31'h0, a < b};
        ex_isa_pkg::OP_CLZ:  wb.wdata = lead_count(a, 1'b0);
        ex_isa_pkg::OP_CLO:  wb.wdata = lead_count(a, 1'b1);
        ex_isa_pkg::OP_MFHI: wb.wdata = model_hilo[63:32];
        ex_isa_pkg::OP_MFLO: wb.wdata = model_hilo[31:0];
        ex_isa_pkg::OP_MTHI: model_hilo[63:32] = a;
        ex_isa_pkg::OP_MTLO: model_hilo[31:0] = a;
        ex_isa_pkg::OP_MUL:  wb.wdata = prod[31:0];
        ex_isa_pkg::OP_MULT, ex_isa_pkg::OP_MULTU: model_hilo = prod;
        ex_isa_pkg::OP_MADD, ex_isa_pkg::OP_MADDU: model_hilo = model_hilo + prod;
        ex_isa_pkg::OP_MSUB, ex_isa_pkg::OP_MSUBU: model_hilo = model_hilo - prod;
        default: ;
    endcase
    if (wb.ov || is_acc_op(r.aluop)) begin
        wb.wreg = 1'b0;
    end
endtask

task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    check_cnt++;
    if (exp !== act) begin
        err_cnt++;
        $display("ERR %s expected %h actual %h", name, exp, act);
    end
endtask

// ==== bench/tb_ex.sv ====
`timescale 1ns/1ns

module tb_ex;

    logic                 clk;
    logic                 rst_n_i;
    ex_pipe_pkg::ex_req_t req_i;
    logic                 req_valid_i;
    logic                 req_ready_o;
    ex_pipe_pkg::ex_wb_t  wb_o;
    logic                 wb_valid_o;

    int                   err_cnt = 0;
    int                   check_cnt = 0;
    int                   cyc = 0;
    int                   seed = 32'h18a8;
    ex_pipe_pkg::ex_wb_t  exp_q[$];
    int                   due_q[$];
    string                name_q[$];

    `include "ex_model.svh"

    ex_top u_ex_top (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .wb_o        (wb_o),
        .wb_valid_o  (wb_valid_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run(input string why);
        err_cnt++;
        $display("%s", why);
        $display("checks %0d errors %0d", check_cnt, err_cnt);
        $display("** FAIL **");
        $finish;
    endtask

    // called 1 ns after a rising edge, returns at the same phase
    task automatic issue_request(input ex_isa_pkg::aluop_e op, input logic [31:0] a,
                                 input logic [31:0] b, input logic wreg);
        ex_pipe_pkg::ex_req_t r;
        ex_pipe_pkg::ex_wb_t  exp;
        logic [31:0]          pick;
        int                   waited;
        pick = $random(seed);
        r.aluop = op;
        r.reg1 = a;
        r.reg2 = b;
        r.wd = pick[4:0];
        r.wreg = wreg;
        req_i = r;
        req_valid_i = 1'b1;
        waited = 0;
        while (!req_ready_o) begin
            if (waited == 10) begin
                abort_run("timeout: req_ready_o stayed low");
            end
            waited++;
            @(posedge clk);
            #1;
        end
        predict_result(r, exp);
        exp_q.push_back(exp);
        due_q.push_back(is_acc_op(op) ? cyc + 2 : cyc + 1);
        name_q.push_back(op.name());
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
        if (is_acc_op(op)) begin
            check_value({op.name(), " stall"}, 64'd0, {63'd0, req_ready_o});
            @(posedge clk);
            #1;
            check_value({op.name(), " release"}, 64'd1, {63'd0, req_ready_o});
        end
    endtask

    task automatic read_hilo();
        issue_request(ex_isa_pkg::OP_MFHI, 32'h0, 32'h0, 1'b1);
        issue_request(ex_isa_pkg::OP_MFLO, 32'h0, 32'h0, 1'b1);
    endtask

    // results checked in issue order, mid cycle
    always @(negedge clk) begin
        if (rst_n_i && wb_valid_o) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("result seen with no request outstanding");
            end else begin
                check_value({name_q[0], " wb"}, {25'd0, exp_q[0]}, {25'd0, wb_o});
                check_value({name_q[0], " cycle"}, 64'(due_q[0]), 64'(cyc));
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
                void'(name_q.pop_front());
            end
        end
    end

    initial begin
        ex_isa_pkg::aluop_e acc_ops[4];
        ex_isa_pkg::aluop_e op;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        rnd;
        int                 waited;
        acc_ops = '{ex_isa_pkg::OP_MADD, ex_isa_pkg::OP_MADDU,
                    ex_isa_pkg::OP_MSUB, ex_isa_pkg::OP_MSUBU};
        clk = 1'b0;
        rst_n_i = 1'b0;
        req_valid_i = 1'b0;
        req_i = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        check_value("reset ready", 64'd1, {63'd0, req_ready_o});
        check_value("reset wb_valid", 64'd0, {63'd0, wb_valid_o});
        read_hilo();
        // signed forms overflow, unsigned forms keep the write
        issue_request(ex_isa_pkg::OP_ADD, 32'h7fffffff, 32'h1, 1'b1);
        issue_request(ex_isa_pkg::OP_ADDU, 32'h7fffffff, 32'h1, 1'b1);
        issue_request(ex_isa_pkg::OP_SUB, 32'h80000000, 32'h1, 1'b1);
        issue_request(ex_isa_pkg::OP_SUBU, 32'h80000000, 32'h1, 1'b1);
        issue_request(ex_isa_pkg::OP_MULT, 32'hfffffffd, 32'h7, 1'b1);
        read_hilo();
        issue_request(ex_isa_pkg::OP_MULTU, 32'hfffffffd, 32'h7, 1'b1);
        read_hilo();
        issue_request(ex_isa_pkg::OP_MUL, 32'h12345678, 32'h9abcdef0, 1'b1);
        read_hilo();
        issue_request(ex_isa_pkg::OP_MTHI, 32'hcafe0001, 32'h0, 1'b1);
        read_hilo();
        issue_request(ex_isa_pkg::OP_MTLO, 32'h0badf00d, 32'h0, 1'b1);
        read_hilo();
        foreach (acc_ops[i]) begin
            a = $random(seed);
            b = $random(seed);
            issue_request(acc_ops[i], a, b, 1'b1);
            read_hilo();
        end
        repeat (400) begin
            rnd = $random(seed);
            op = ex_isa_pkg::aluop_e'(rnd % 27);
            a = $random(seed);
            b = $random(seed);
            // shifted operands give clz/clo some long runs
            if (rnd[8]) begin
                a = rnd[9] ? ~(a >> rnd[14:10]) : (a >> rnd[14:10]);
            end
            issue_request(op, a, b, rnd[15]);
            repeat (rnd[17:16] % 3) begin
                @(posedge clk);
                #1;
            end
        end
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == 20) begin
                abort_run("timeout: results still outstanding at the end");
            end
            waited++;
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        $display("checks %0d errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_ex -o tb_ex_sim \
    && ./obj_dir/tb_ex_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
exit 0

// ==== sim.f ====
+incdir+bench
verilog/ex_isa_pkg.sv
verilog/ex_pipe_pkg.sv
verilog/ex_alu.sv
verilog/ex_mul.sv
verilog/ex_hilo.sv
verilog/ex_result.sv
verilog/ex_top.sv
bench/tb_ex.sv

// ==== verilog/ex_alu.sv ====
`timescale 1ns/1ns

module ex_alu (
    input  ex_pipe_pkg::ex_req_t          req_i,
    input  logic [ex_isa_pkg::DREG_W-1:0] hilo_i,
    output logic [ex_isa_pkg::REG_W-1:0]  alu_data_o,
    output logic                          alu_ov_o,
    output ex_pipe_pkg::hilo_wr_t         hilo_wr_o
);

    localparam int MSB = ex_isa_pkg::REG_W - 1;

    logic [ex_isa_pkg::REG_W-1:0]   op1;
    logic [ex_isa_pkg::REG_W-1:0]   op2;
    logic [ex_isa_pkg::REG_W-1:0]   op2_eff;
    logic [ex_isa_pkg::REG_W-1:0]   sum;
    logic [ex_isa_pkg::SHAMT_W-1:0] shamt;
    logic [ex_isa_pkg::REG_W-1:0]   hi;
    logic [ex_isa_pkg::REG_W-1:0]   lo;
    logic                           is_sub;
    logic                           op2_sign;
    logic                           sum_ov;
    logic                           lt_signed;
    logic                           lt_unsigned;

    // number of leading bits equal to lead
    function automatic logic [ex_isa_pkg::REG_W-1:0] count_lead(
        input logic [ex_isa_pkg::REG_W-1:0] val,
        input logic                         lead
    );
        logic [ex_isa_pkg::REG_W-1:0] cnt;
        logic                         run;
        cnt = '0;
        run = 1'b1;
        for (int i = MSB; i >= 0; i--) begin
            if (run && (val[i] == lead)) begin
                cnt = cnt + 1'b1;
            end else begin
                run = 1'b0;
            end
        end
        return cnt;
    endfunction

    assign op1   = req_i.reg1;
    assign op2   = req_i.reg2;
    assign shamt = op1[ex_isa_pkg::SHAMT_W-1:0];
    assign hi    = hilo_i[ex_isa_pkg::DREG_W-1:ex_isa_pkg::REG_W];
    assign lo    = hilo_i[ex_isa_pkg::REG_W-1:0];

    assign is_sub = (req_i.aluop == ex_isa_pkg::OP_SUB) ||
                    (req_i.aluop == ex_isa_pkg::OP_SUBU) ||
                    (req_i.aluop == ex_isa_pkg::OP_SLT);

    assign op2_eff = is_sub ? (~op2 + 1'b1) : op2;
    assign sum     = op1 + op2_eff;

    // sign of the operand as it is meant, also right for op2 = 0x80000000
    assign op2_sign    = is_sub ? ~op2[MSB] : op2[MSB];
    assign sum_ov      = (op1[MSB] == op2_sign) && (sum[MSB] != op1[MSB]);
    assign lt_signed   = sum_ov ? ~sum[MSB] : sum[MSB];
    assign lt_unsigned = op1 < op2;

    assign alu_ov_o = sum_ov && ((req_i.aluop == ex_isa_pkg::OP_ADD) ||
                                 (req_i.aluop == ex_isa_pkg::OP_SUB));

    always_comb begin
        case (req_i.aluop)
            ex_isa_pkg::OP_AND:  alu_data_o = op1 & op2;
            ex_isa_pkg::OP_OR:   alu_data_o = op1 | op2;
            ex_isa_pkg::OP_XOR:  alu_data_o = op1 ^ op2;
            ex_isa_pkg::OP_NOR:  alu_data_o = ~(op1 | op2);
            ex_isa_pkg::OP_SLL:  alu_data_o = op2 << shamt;
            ex_isa_pkg::OP_SRL:  alu_data_o = op2 >> shamt;
            ex_isa_pkg::OP_SRA:  alu_data_o = $signed(op2) >>> shamt;
            ex_isa_pkg::OP_ADD,
            ex_isa_pkg::OP_ADDU,
            ex_isa_pkg::OP_SUB,
            ex_isa_pkg::OP_SUBU: alu_data_o = sum;
            ex_isa_pkg::OP_SLT:  alu_data_o = {{MSB{1'b0}}, lt_signed};
            ex_isa_pkg::OP_SLTU: alu_data_o = {{MSB{1'b0}}, lt_unsigned};
            ex_isa_pkg::OP_CLZ:  alu_data_o = count_lead(op1, 1'b0);
            ex_isa_pkg::OP_CLO:  alu_data_o = count_lead(op1, 1'b1);
            ex_isa_pkg::OP_MFHI: alu_data_o = hi;
            ex_isa_pkg::OP_MFLO: alu_data_o = lo;
            default:             alu_data_o = '0;
        endcase
    end

    // mthi/mtlo keep the other half
    always_comb begin
        hilo_wr_o.we   = 1'b0;
        hilo_wr_o.hilo = hilo_i;
        if (req_i.aluop == ex_isa_pkg::OP_MTHI) begin
            hilo_wr_o.we   = 1'b1;
            hilo_wr_o.hilo = {op1, lo};
        end else if (req_i.aluop == ex_isa_pkg::OP_MTLO) begin
            hilo_wr_o.we   = 1'b1;
            hilo_wr_o.hilo = {hi, op1};
        end
    end

endmodule

// ==== verilog/ex_hilo.sv ====
`timescale 1ns/1ns

module ex_hilo (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  ex_pipe_pkg::hilo_wr_t         alu_wr_i,
    input  ex_pipe_pkg::hilo_wr_t         mul_wr_i,
    output logic [ex_isa_pkg::DREG_W-1:0] hilo_o
);

    logic [ex_isa_pkg::REG_W-1:0] hi_q;
    logic [ex_isa_pkg::REG_W-1:0] lo_q;
    logic [ex_isa_pkg::REG_W-1:0] hi_d;
    logic [ex_isa_pkg::REG_W-1:0] lo_d;
    logic                         we;

    // opcodes of the two writers never overlap
    always_comb begin
        we = alu_wr_i.we || mul_wr_i.we;
        if (alu_wr_i.we) begin
            {hi_d, lo_d} = alu_wr_i.hilo;
        end else begin
            {hi_d, lo_d} = mul_wr_i.hilo;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (we) begin
            hi_q <= hi_d;
            lo_q <= lo_d;
        end
    end

    assign hilo_o = {hi_q, lo_q};

endmodule

// ==== verilog/ex_isa_pkg.sv ====
package ex_isa_pkg;

    localparam int REG_W      = 32;
    localparam int DREG_W     = 64;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    // decoded opcodes, immediates already placed in reg2
    typedef enum logic [4:0] {
        OP_NOP   = 5'd0,
        OP_AND   = 5'd1,
        OP_OR    = 5'd2,
        OP_XOR   = 5'd3,
        OP_NOR   = 5'd4,
        OP_SLL   = 5'd5,
        OP_SRL   = 5'd6,
        OP_SRA   = 5'd7,
        OP_ADD   = 5'd8,
        OP_ADDU  = 5'd9,
        OP_SUB   = 5'd10,
        OP_SUBU  = 5'd11,
        OP_SLT   = 5'd12,
        OP_SLTU  = 5'd13,
        OP_CLZ   = 5'd14,
        OP_CLO   = 5'd15,
        OP_MFHI  = 5'd16,
        OP_MFLO  = 5'd17,
        OP_MTHI  = 5'd18,
        OP_MTLO  = 5'd19,
        OP_MUL   = 5'd20,
        OP_MULT  = 5'd21,
        OP_MULTU = 5'd22,
        OP_MADD  = 5'd23,
        OP_MADDU = 5'd24,
        OP_MSUB  = 5'd25,
        OP_MSUBU = 5'd26
    } aluop_e;

    // which datapath feeds the write-back word
    typedef enum logic [2:0] {
        GRP_LOGIC = 3'd0,
        GRP_SHIFT = 3'd1,
        GRP_ARITH = 3'd2,
        GRP_MOVE  = 3'd3,
        GRP_MUL   = 3'd4,
        GRP_NONE  = 3'd5
    } res_grp_e;

endpackage

// ==== verilog/ex_mul.sv ====
`timescale 1ns/1ns

module ex_mul (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  ex_pipe_pkg::ex_req_t          req_i,
    input  logic                          req_valid_i,
    input  logic [ex_isa_pkg::DREG_W-1:0] hilo_i,
    output logic [ex_isa_pkg::REG_W-1:0]  mul_lo_o,
    output ex_pipe_pkg::hilo_wr_t         hilo_wr_o,
    output logic                          req_ready_o,
    output logic                          acc_done_o
);

    localparam int MSB = ex_isa_pkg::REG_W - 1;

    typedef enum logic {
        IDLE,
        ACC
    } acc_state_e;

    acc_state_e                    state_q;
    acc_state_e                    state_d;
    logic                          is_signed;
    logic                          is_acc;
    logic                          is_msub;
    logic                          is_mult;
    logic                          req_fire;
    logic                          neg;
    logic [ex_isa_pkg::REG_W-1:0]  mag1;
    logic [ex_isa_pkg::REG_W-1:0]  mag2;
    logic [ex_isa_pkg::DREG_W-1:0] mag_prod;
    logic [ex_isa_pkg::DREG_W-1:0] prod;
    logic [ex_isa_pkg::DREG_W-1:0] acc_q;

    assign is_signed = (req_i.aluop == ex_isa_pkg::OP_MUL) ||
                       (req_i.aluop == ex_isa_pkg::OP_MULT) ||
                       (req_i.aluop == ex_isa_pkg::OP_MADD) ||
                       (req_i.aluop == ex_isa_pkg::OP_MSUB);
    assign is_msub   = (req_i.aluop == ex_isa_pkg::OP_MSUB) ||
                       (req_i.aluop == ex_isa_pkg::OP_MSUBU);
    assign is_acc    = is_msub || (req_i.aluop == ex_isa_pkg::OP_MADD) ||
                       (req_i.aluop == ex_isa_pkg::OP_MADDU);
    assign is_mult   = (req_i.aluop == ex_isa_pkg::OP_MULT) ||
                       (req_i.aluop == ex_isa_pkg::OP_MULTU);

    // multiply magnitudes, fix the sign afterwards
    assign mag1     = (is_signed && req_i.reg1[MSB]) ? (~req_i.reg1 + 1'b1) : req_i.reg1;
    assign mag2     = (is_signed && req_i.reg2[MSB]) ? (~req_i.reg2 + 1'b1) : req_i.reg2;
    assign mag_prod = mag1 * mag2;
    assign neg      = is_signed && (req_i.reg1[MSB] ^ req_i.reg2[MSB]);
    assign prod     = neg ? (~mag_prod + 1'b1) : mag_prod;
    assign mul_lo_o = prod[ex_isa_pkg::REG_W-1:0];

    assign req_ready_o = (state_q == IDLE);
    assign acc_done_o  = (state_q == ACC);
    assign req_fire    = req_valid_i && req_ready_o;

    always_comb begin
        state_d = IDLE;
        if ((state_q == IDLE) && req_fire && is_acc) begin
            state_d = ACC;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // product to add in the second cycle, negated for msub
    always_ff @(posedge clk) begin
        if (req_fire && is_acc) begin
            acc_q <= is_msub ? (~prod + 1'b1) : prod;
        end
    end

    always_comb begin
        hilo_wr_o.we   = 1'b0;
        hilo_wr_o.hilo = prod;
        if (state_q == ACC) begin
            hilo_wr_o.we   = 1'b1;
            hilo_wr_o.hilo = hilo_i + acc_q;
        end else if (req_fire && is_mult) begin
            hilo_wr_o.we = 1'b1;
        end
    end

endmodule

// ==== verilog/ex_pipe_pkg.sv ====
package ex_pipe_pkg;

    // issue request from decode
    typedef struct packed {
        ex_isa_pkg::aluop_e                aluop;
        logic [ex_isa_pkg::REG_W-1:0]      reg1;
        logic [ex_isa_pkg::REG_W-1:0]      reg2;
        logic [ex_isa_pkg::REG_ADDR_W-1:0] wd;
        logic                              wreg;
    } ex_req_t;

    // write-back result
    typedef struct packed {
        logic [ex_isa_pkg::REG_ADDR_W-1:0] wd;
        logic                              wreg;
        logic                              ov;
        logic [ex_isa_pkg::REG_W-1:0]      wdata;
    } ex_wb_t;

    // HI/LO update, hi in the upper half
    typedef struct packed {
        logic                              we;
        logic [ex_isa_pkg::DREG_W-1:0]     hilo;
    } hilo_wr_t;

endpackage

// ==== verilog/ex_result.sv ====
`timescale 1ns/1ns

module ex_result (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  ex_pipe_pkg::ex_req_t         req_i,
    input  logic                         req_valid_i,
    input  logic                         req_ready_i,
    input  logic [ex_isa_pkg::REG_W-1:0] alu_data_i,
    input  logic                         alu_ov_i,
    input  logic [ex_isa_pkg::REG_W-1:0] mul_lo_i,
    input  logic                         acc_done_i,
    output ex_pipe_pkg::ex_wb_t          wb_o,
    output logic                         wb_valid_o
);

    ex_isa_pkg::res_grp_e grp;
    ex_pipe_pkg::ex_wb_t  wb_d;
    ex_pipe_pkg::ex_wb_t  wb_q;
    logic                 wb_valid_q;
    logic                 req_fire;
    logic                 is_acc;

    function automatic ex_isa_pkg::res_grp_e grp_of(input ex_isa_pkg::aluop_e op);
        case (op)
            ex_isa_pkg::OP_AND, ex_isa_pkg::OP_OR,
            ex_isa_pkg::OP_XOR, ex_isa_pkg::OP_NOR:  return ex_isa_pkg::GRP_LOGIC;
            ex_isa_pkg::OP_SLL, ex_isa_pkg::OP_SRL,
            ex_isa_pkg::OP_SRA:                      return ex_isa_pkg::GRP_SHIFT;
            ex_isa_pkg::OP_ADD, ex_isa_pkg::OP_ADDU,
            ex_isa_pkg::OP_SUB, ex_isa_pkg::OP_SUBU,
            ex_isa_pkg::OP_SLT, ex_isa_pkg::OP_SLTU,
            ex_isa_pkg::OP_CLZ, ex_isa_pkg::OP_CLO:  return ex_isa_pkg::GRP_ARITH;
            ex_isa_pkg::OP_MFHI, ex_isa_pkg::OP_MFLO: return ex_isa_pkg::GRP_MOVE;
            ex_isa_pkg::OP_MUL:                      return ex_isa_pkg::GRP_MUL;
            default:                                 return ex_isa_pkg::GRP_NONE;
        endcase
    endfunction

    assign req_fire = req_valid_i && req_ready_i;
    assign is_acc   = (req_i.aluop == ex_isa_pkg::OP_MADD) ||
                      (req_i.aluop == ex_isa_pkg::OP_MADDU) ||
                      (req_i.aluop == ex_isa_pkg::OP_MSUB) ||
                      (req_i.aluop == ex_isa_pkg::OP_MSUBU);

    always_comb begin
        grp     = grp_of(req_i.aluop);
        wb_d.wd = req_i.wd;
        wb_d.ov = alu_ov_i;
        // overflow cancels the write, madd/msub never write a register
        wb_d.wreg = req_i.wreg && !alu_ov_i && !is_acc;
        case (grp)
            ex_isa_pkg::GRP_MUL:  wb_d.wdata = mul_lo_i;
            ex_isa_pkg::GRP_NONE: wb_d.wdata = '0;
            default:              wb_d.wdata = alu_data_i;
        endcase
    end

    // madd/msub result is held until the accumulate cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= (req_fire && !is_acc) || acc_done_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            wb_q <= wb_d;
        end
    end

    assign wb_o       = wb_q;
    assign wb_valid_o = wb_valid_q;

endmodule

// ==== verilog/ex_top.sv ====
`timescale 1ns/1ns

module ex_top (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  ex_pipe_pkg::ex_req_t req_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    output ex_pipe_pkg::ex_wb_t  wb_o,
    output logic                 wb_valid_o
);

    logic [ex_isa_pkg::DREG_W-1:0] hilo;
    logic [ex_isa_pkg::REG_W-1:0]  alu_data;
    logic                          alu_ov;
    ex_pipe_pkg::hilo_wr_t         alu_hilo_wr;
    ex_pipe_pkg::hilo_wr_t         alu_hilo_wr_acc;
    logic [ex_isa_pkg::REG_W-1:0]  mul_lo;
    ex_pipe_pkg::hilo_wr_t         mul_hilo_wr;
    logic                          acc_done;

    // mthi/mtlo only land for an accepted request
    assign alu_hilo_wr_acc = '{we:   alu_hilo_wr.we & req_valid_i & req_ready_o,
                               hilo: alu_hilo_wr.hilo};

    ex_alu u_ex_alu (
        .req_i      (req_i),
        .hilo_i     (hilo),
        .alu_data_o (alu_data),
        .alu_ov_o   (alu_ov),
        .hilo_wr_o  (alu_hilo_wr)
    );

    ex_mul u_ex_mul (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .hilo_i      (hilo),
        .mul_lo_o    (mul_lo),
        .hilo_wr_o   (mul_hilo_wr),
        .req_ready_o (req_ready_o),
        .acc_done_o  (acc_done)
    );

    ex_hilo u_ex_hilo (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .alu_wr_i (alu_hilo_wr_acc),
        .mul_wr_i (mul_hilo_wr),
        .hilo_o   (hilo)
    );

    ex_result u_ex_result (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_i (req_ready_o),
        .alu_data_i  (alu_data),
        .alu_ov_i    (alu_ov),
        .mul_lo_i    (mul_lo),
        .acc_done_i  (acc_done),
        .wb_o        (wb_o),
        .wb_valid_o  (wb_valid_o)
    );

endmodule
